/* hdl/snes_load_pkg.sv */
`default_nettype none

package snes_load_pkg;

	// Host download stream
	typedef logic [15:0] io_word_t;
	typedef logic [24:0] io_addr_t;
	typedef logic [7:0]  io_index_t;

	// Cartridge header fields
	typedef logic [7:0]  rom_type_t;
	typedef logic [3:0]  size_code_t;
	typedef logic [23:0] mem_mask_t;

	typedef logic [7:0]   wram_byte_t;
	// Flags, address, compare, replace from top to bottom
	typedef logic [127:0] cheat_code_t;

	typedef enum logic [2:0] {
		HDR_AUTO,
		HDR_NONE,
		HDR_LOROM,
		HDR_HIROM,
		HDR_EXHIROM
	} header_mode_e;

	typedef enum logic [1:0] {
		FILL_9966,
		FILL_00FF,
		FILL_55,
		FILL_FF
	} fill_pattern_e;

	// Encoding 3 is treated as PAL as well
	typedef enum logic [1:0] {
		REGION_AUTO = 2'd0,
		REGION_NTSC = 2'd1,
		REGION_PAL  = 2'd2
	} region_sel_e;

	// Copier header in front of the image
	localparam io_addr_t HEADER_SKIP = 25'd512;

	// Size word in each layout, RAM size word sits 2 above
	localparam io_addr_t LOROM_INFO   = 25'h007FD6 + HEADER_SKIP;
	localparam io_addr_t HIROM_INFO   = 25'h00FFD6 + HEADER_SKIP;
	localparam io_addr_t EXHIROM_INFO = 25'h40FFD6 + HEADER_SKIP;

	localparam io_index_t IDX_CART = 8'h01;
	localparam io_index_t IDX_CODE = 8'hFF;

endpackage

`default_nettype wire

/* hdl/cart_header_decoder.sv */
`default_nettype none

module cart_header_decoder import snes_load_pkg::*; (
	input  wire         clk_sys,
	input  wire         RESET,
	input  wire         ioctl_download_i,
	input  io_index_t   ioctl_index_i,
	input  io_addr_t    ioctl_addr_i,
	input  io_word_t    ioctl_dout_i,
	input  wire         ioctl_wr_i,
	input  header_mode_e header_mode_i,
	input  region_sel_e region_sel_i,
	output logic        cart_active_o,
	output logic        cart_start_o,
	output logic        code_wr_o,
	output rom_type_t   rom_type_o,
	output mem_mask_t   rom_mask_o,
	output mem_mask_t   ram_mask_o,
	output logic        pal_o
);

	logic       cart_dl;
	logic       code_dl;
	logic       cart_dl_q;
	logic       mask_upd;
	logic       rom_region;
	logic       has_info;
	io_addr_t   info_addr;
	size_code_t rom_size;
	size_code_t ram_size;

	function automatic mem_mask_t size_mask(input size_code_t code);
		mem_mask_t one_k;
		one_k = 24'd1024;
		return (one_k << code) - 24'd1;
	endfunction

	// Index 0 is the boot ROM, which loads like a cartridge
	assign cart_dl = ioctl_download_i &
		((ioctl_index_i[5:0] == IDX_CART[5:0]) | (ioctl_index_i == '0));
	assign code_dl = ioctl_download_i & (ioctl_index_i == IDX_CODE);

	assign cart_active_o = cart_dl;
	assign code_wr_o     = code_dl & ioctl_wr_i;

	// Where the size words live for the forced layouts
	always_comb begin
		has_info  = 1'b1;
		info_addr = '0;
		case (header_mode_i)
			HDR_LOROM:   info_addr = LOROM_INFO;
			HDR_HIROM:   info_addr = HIROM_INFO;
			HDR_EXHIROM: info_addr = EXHIROM_INFO;
			default:     has_info  = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q    <= 1'b0;
			cart_start_o <= 1'b0;
			mask_upd     <= 1'b0;
			rom_mask_o   <= '0;
			ram_mask_o   <= '0;
		end else begin
			cart_dl_q    <= cart_dl;
			cart_start_o <= cart_dl & ~cart_dl_q;
			mask_upd     <= cart_dl & ioctl_wr_i;
			// Masks follow the sizes stored on the previous edge
			if (mask_upd) begin
				rom_mask_o <= size_mask(rom_size);
				ram_mask_o <= (ram_size != '0) ? size_mask(ram_size) : '0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= '0;
			ram_size   <= '0;
			rom_type_o <= '0;
			rom_region <= 1'b0;
			pal_o      <= 1'b0;
		end else if (cart_dl) begin
			if (ioctl_wr_i) begin
				if (ioctl_addr_i == '0) begin
					rom_size <= 4'hC;
					ram_size <= '0;
					if (header_mode_i == HDR_AUTO && ioctl_dout_i[7:0] != '0)
						{ram_size, rom_size} <= ioctl_dout_i[7:0];
					case (header_mode_i)
						HDR_NONE, HDR_LOROM: rom_type_o <= 8'd0;
						HDR_HIROM:           rom_type_o <= 8'd1;
						HDR_EXHIROM:         rom_type_o <= 8'd2;
						default:             rom_type_o <= ioctl_dout_i[15:8];
					endcase
				end
				if (ioctl_addr_i == 25'd2)
					rom_region <= ioctl_dout_i[8];
				if (has_info && ioctl_addr_i == info_addr)
					rom_size <= ioctl_dout_i[11:8];
				if (has_info && ioctl_addr_i == info_addr + 25'd2)
					ram_size <= ioctl_dout_i[3:0];
			end
		end else begin
			// Region only moves between loads
			pal_o <= (region_sel_i == REGION_AUTO) ? rom_region : region_sel_i[1];
		end
	end

endmodule

`default_nettype wire

/* hdl/wram_fill_engine.sv */
`default_nettype none

module wram_fill_engine import snes_load_pkg::*; #(
	parameter int WRAM_ADDR_BITS = 17
) (
	input  wire                       clk_sys,
	input  wire                       RESET,
	input  wire                       cart_start_i,
	input  wire                       cart_active_i,
	input  fill_pattern_e             fill_pattern_i,
	output logic [WRAM_ADDR_BITS-1:0] fill_addr_o,
	output wram_byte_t                fill_data_o,
	output logic                      fill_we_o,
	output logic                      clearing_o,
	output logic                      hold_o
);

	logic fill_wait;

	// One write every two cycles, the odd cycle is idle
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing_o  <= 1'b0;
			fill_wait   <= 1'b0;
			fill_addr_o <= '0;
		end else if (cart_start_i) begin
			clearing_o  <= 1'b1;
			fill_wait   <= 1'b0;
			fill_addr_o <= '0;
		end else if (clearing_o) begin
			fill_wait <= ~fill_wait;
			if (fill_wait)
				fill_addr_o <= fill_addr_o + 1'b1;
			// Done after the idle cycle that follows the last address
			if (fill_wait && &fill_addr_o)
				clearing_o <= 1'b0;
		end else begin
			fill_wait   <= 1'b0;
			fill_addr_o <= '0;
		end
	end

	assign fill_we_o = clearing_o & ~fill_wait;

	// Power-on patterns as seen on the different console revisions
	always_comb begin
		case (fill_pattern_i)
			FILL_9966:
				fill_data_o = (fill_addr_o[8] ^ fill_addr_o[2]) ? 8'h66 : 8'h99;
			FILL_00FF:
				fill_data_o = (fill_addr_o[9] ^ fill_addr_o[0]) ? 8'hFF : 8'h00;
			FILL_55:
				fill_data_o = 8'h55;
			default:
				fill_data_o = 8'hFF;
		endcase
	end

	// The system stays held through the download and the fill
	assign hold_o = cart_active_i | clearing_o;

endmodule

`default_nettype wire

/* hdl/wram_store.sv */
`default_nettype none

module wram_store import snes_load_pkg::*; #(
	parameter int WRAM_ADDR_BITS = 17
) (
	input  wire                      clk_sys,
	input  wire                      clearing_i,
	input  wire [WRAM_ADDR_BITS-1:0] fill_addr_i,
	input  wram_byte_t               fill_data_i,
	input  wire                      fill_we_i,
	input  wire [WRAM_ADDR_BITS-1:0] cpu_addr_i,
	input  wram_byte_t               cpu_din_i,
	input  wire                      cpu_we_i,
	output wram_byte_t               cpu_dout_o
);

	wram_byte_t mem [0:(1<<WRAM_ADDR_BITS)-1];

	always_ff @(posedge clk_sys) begin
		if (clearing_i) begin
			if (fill_we_i)
				mem[fill_addr_i] <= fill_data_i;
		end else if (cpu_we_i) begin
			mem[cpu_addr_i] <= cpu_din_i;
		end
		cpu_dout_o <= mem[cpu_addr_i];
	end

endmodule

`default_nettype wire

/* hdl/cheat_code_assembler.sv */
`default_nettype none

module cheat_code_assembler import snes_load_pkg::*; (
	input  wire         clk_sys,
	input  wire         RESET,
	input  wire         code_wr_i,
	input  wire         cart_active_i,
	input  io_addr_t    ioctl_addr_i,
	input  io_word_t    ioctl_dout_i,
	output cheat_code_t code_o,
	output logic        code_valid_o,
	output logic        code_clear_o
);

	// Each code is 16 bytes, low word of a field comes first
	always_ff @(posedge clk_sys) begin
		if (code_wr_i) begin
			case (ioctl_addr_i[3:0])
				4'd0:  code_o[111:96]  <= ioctl_dout_i;
				4'd2:  code_o[127:112] <= ioctl_dout_i;
				4'd4:  code_o[79:64]   <= ioctl_dout_i;
				4'd6:  code_o[95:80]   <= ioctl_dout_i;
				4'd8:  code_o[47:32]   <= ioctl_dout_i;
				4'd10: code_o[63:48]   <= ioctl_dout_i;
				4'd12: code_o[15:0]    <= ioctl_dout_i;
				4'd14: code_o[31:16]   <= ioctl_dout_i;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid_o <= 1'b0;
			code_clear_o <= 1'b0;
		end else begin
			// Last word of a code completes it
			code_valid_o <= code_wr_i && (ioctl_addr_i[3:0] == 4'd14);
			// A new cheat list or a new cartridge drops all old codes
			code_clear_o <= cart_active_i | (code_wr_i && (ioctl_addr_i == '0));
		end
	end

endmodule

`default_nettype wire

/* hdl/cart_loader_top.sv */
`default_nettype none

module cart_loader_top import snes_load_pkg::*; #(
	parameter int WRAM_ADDR_BITS = 17
) (
	input  wire                      clk_sys,
	input  wire                      RESET,
	input  wire                      ioctl_download_i,
	input  io_index_t                ioctl_index_i,
	input  io_addr_t                 ioctl_addr_i,
	input  io_word_t                 ioctl_dout_i,
	input  wire                      ioctl_wr_i,
	input  header_mode_e             header_mode_i,
	input  region_sel_e              region_sel_i,
	input  fill_pattern_e            fill_pattern_i,
	input  wire [WRAM_ADDR_BITS-1:0] cpu_addr_i,
	input  wram_byte_t               cpu_din_i,
	input  wire                      cpu_we_i,
	output rom_type_t                rom_type_o,
	output mem_mask_t                rom_mask_o,
	output mem_mask_t                ram_mask_o,
	output logic                     pal_o,
	output logic                     hold_o,
	output wram_byte_t               cpu_dout_o,
	output cheat_code_t              code_o,
	output logic                     code_valid_o,
	output logic                     code_clear_o
);

	logic                      cart_active;
	logic                      cart_start;
	logic                      code_wr;
	logic                      clearing;
	logic [WRAM_ADDR_BITS-1:0] fill_addr;
	wram_byte_t                fill_data;
	logic                      fill_we;

	cart_header_decoder u_decoder (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.header_mode_i    (header_mode_i),
		.region_sel_i     (region_sel_i),
		.cart_active_o    (cart_active),
		.cart_start_o     (cart_start),
		.code_wr_o        (code_wr),
		.rom_type_o       (rom_type_o),
		.rom_mask_o       (rom_mask_o),
		.ram_mask_o       (ram_mask_o),
		.pal_o            (pal_o)
	);

	wram_fill_engine #(
		.WRAM_ADDR_BITS (WRAM_ADDR_BITS)
	) u_fill (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.cart_start_i   (cart_start),
		.cart_active_i  (cart_active),
		.fill_pattern_i (fill_pattern_i),
		.fill_addr_o    (fill_addr),
		.fill_data_o    (fill_data),
		.fill_we_o      (fill_we),
		.clearing_o     (clearing),
		.hold_o         (hold_o)
	);

	wram_store #(
		.WRAM_ADDR_BITS (WRAM_ADDR_BITS)
	) u_wram (
		.clk_sys     (clk_sys),
		.clearing_i  (clearing),
		.fill_addr_i (fill_addr),
		.fill_data_i (fill_data),
		.fill_we_i   (fill_we),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_din_i   (cpu_din_i),
		.cpu_we_i    (cpu_we_i),
		.cpu_dout_o  (cpu_dout_o)
	);

	cheat_code_assembler u_cheat (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.code_wr_i     (code_wr),
		.cart_active_i (cart_active),
		.ioctl_addr_i  (ioctl_addr_i),
		.ioctl_dout_i  (ioctl_dout_i),
		.code_o        (code_o),
		.code_valid_o  (code_valid_o),
		.code_clear_o  (code_clear_o)
	);

endmodule

`default_nettype wire

/* dv/cart_loader_assert.sv */
`default_nettype none

module cart_loader_assert (
	input wire clk_sys,
	input wire RESET,
	input wire cart_active_i,
	input wire hold_i,
	input wire pal_i,
	input wire code_valid_i
);

	// A finished code is announced once
	valid_single: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid_i |=> !code_valid_i)
		else $error("code_valid_o stayed high for two cycles");

	hold_covers_load: assert property (@(posedge clk_sys) disable iff (RESET)
		cart_active_i |-> hold_i)
		else $error("hold_o low during a cartridge download");

	// Region is frozen while a load is in progress
	pal_frozen: assert property (@(posedge clk_sys) disable iff (RESET)
		$past(cart_active_i) |-> $stable(pal_i))
		else $error("pal_o changed during a cartridge download");

endmodule

bind cart_loader_top cart_loader_assert u_assert (
	.clk_sys       (clk_sys),
	.RESET         (RESET),
	.cart_active_i (cart_active),
	.hold_i        (hold_o),
	.pal_i         (pal_o),
	.code_valid_i  (code_valid_o)
);

`default_nettype wire

/* dv/cart_loader_tb.sv */
`default_nettype none

module cart_loader_tb import snes_load_pkg::*; ();

	localparam int WRAM_ADDR_BITS = 10;
	localparam int WRAM_DEPTH     = 1 << WRAM_ADDR_BITS;
	localparam int FILL_CYCLES    = 2 * WRAM_DEPTH;
	localparam int REC_WORDS      = 16;
	localparam int MAX_RECS       = 32;

	logic                      clk_sys;
	logic                      RESET;
	logic                      ioctl_download_i;
	io_index_t                 ioctl_index_i;
	io_addr_t                  ioctl_addr_i;
	io_word_t                  ioctl_dout_i;
	logic                      ioctl_wr_i;
	header_mode_e              header_mode_i;
	region_sel_e               region_sel_i;
	fill_pattern_e             fill_pattern_i;
	logic [WRAM_ADDR_BITS-1:0] cpu_addr_i;
	wram_byte_t                cpu_din_i;
	logic                      cpu_we_i;
	rom_type_t                 rom_type_o;
	mem_mask_t                 rom_mask_o;
	mem_mask_t                 ram_mask_o;
	logic                      pal_o;
	logic                      hold_o;
	wram_byte_t                cpu_dout_o;
	cheat_code_t               code_o;
	logic                      code_valid_o;
	logic                      code_clear_o;

	logic [31:0] rec_mem [0:MAX_RECS*REC_WORDS-1];
	int          errors;
	int          rec_count;
	int          cart_count;
	int          cycle_count;
	int          limit_cycles;
	int          hold_count;
	int          valid_count;
	int          clear_count;

	cart_loader_top #(
		.WRAM_ADDR_BITS (WRAM_ADDR_BITS)
	) DUT (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.header_mode_i    (header_mode_i),
		.region_sel_i     (region_sel_i),
		.fill_pattern_i   (fill_pattern_i),
		.cpu_addr_i       (cpu_addr_i),
		.cpu_din_i        (cpu_din_i),
		.cpu_we_i         (cpu_we_i),
		.rom_type_o       (rom_type_o),
		.rom_mask_o       (rom_mask_o),
		.ram_mask_o       (ram_mask_o),
		.pal_o            (pal_o),
		.hold_o           (hold_o),
		.cpu_dout_o       (cpu_dout_o),
		.code_o           (code_o),
		.code_valid_o     (code_valid_o),
		.code_clear_o     (code_clear_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= limit_cycles) begin
			$display("Timeout: run still busy after %0d cycles", cycle_count);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// Strobe and level counters sampled mid-cycle
	always @(negedge clk_sys) begin
		if (hold_o)
			hold_count <= hold_count + 1;
		if (code_valid_o)
			valid_count <= valid_count + 1;
		if (code_clear_o)
			clear_count <= clear_count + 1;
	end

	// Power-on pattern of one work-RAM address
	function automatic wram_byte_t fill_value(input fill_pattern_e pat,
			input logic [WRAM_ADDR_BITS-1:0] a);
		case (pat)
			FILL_9966: fill_value = (a[8] != a[2]) ? 8'h66 : 8'h99;
			FILL_00FF: fill_value = (a[9] != a[0]) ? 8'hFF : 8'h00;
			FILL_55:   fill_value = 8'h55;
			default:   fill_value = 8'hFF;
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		errors++;
		$display("CHECK FAILED at %0t: %s = %0h, expected %0h", $time, name, got, exp);
	endtask

	task automatic host_write(input io_addr_t addr, input io_word_t data);
		@(posedge clk_sys);
		ioctl_addr_i <= addr;
		ioctl_dout_i <= data;
		ioctl_wr_i   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr_i   <= 1'b0;
	endtask

	task automatic run_cart(input int b);
		io_addr_t                  info_addr;
		fill_pattern_e             pattern;
		wram_byte_t                exp_byte;
		logic [WRAM_ADDR_BITS-1:0] lost_addr;
		wram_byte_t                lost_byte;
		info_addr = rec_mem[b+6][24:0];
		pattern   = fill_pattern_e'(rec_mem[b+3][1:0]);
		lost_addr = rec_mem[b+13][WRAM_ADDR_BITS-1:0];
		lost_byte = rec_mem[b+14][7:0];
		// A lost write only shows if its byte differs from the fill byte
		if (lost_byte == fill_value(pattern, lost_addr))
			lost_byte = ~lost_byte;
		@(posedge clk_sys);
		hold_count       = 0;
		header_mode_i    <= header_mode_e'(rec_mem[b+1][2:0]);
		region_sel_i     <= region_sel_e'(rec_mem[b+2][1:0]);
		fill_pattern_i   <= pattern;
		ioctl_index_i    <= IDX_CART;
		ioctl_download_i <= 1'b1;
		host_write(25'd0, rec_mem[b+4][15:0]);
		host_write(25'd2, rec_mem[b+5][15:0]);
		if (info_addr != '0) begin
			host_write(info_addr, rec_mem[b+7][15:0]);
			host_write(info_addr + 25'd2, rec_mem[b+8][15:0]);
		end
		@(posedge clk_sys);
		ioctl_download_i <= 1'b0;
		// Lands in the middle of the fill
		cpu_addr_i <= lost_addr;
		cpu_din_i  <= lost_byte;
		cpu_we_i   <= 1'b1;
		@(posedge clk_sys);
		cpu_we_i   <= 1'b0;
		@(negedge clk_sys);
		while (hold_o)
			@(negedge clk_sys);
		// Start pulse then one fill cycle pair per address
		if (hold_count != 2 + FILL_CYCLES)
			report_mismatch("hold_o cycles", hold_count, 2 + FILL_CYCLES);
		if (rom_type_o !== rec_mem[b+9][7:0])
			report_mismatch("rom_type_o", rom_type_o, rec_mem[b+9][7:0]);
		if (rom_mask_o !== rec_mem[b+10][23:0])
			report_mismatch("rom_mask_o", rom_mask_o, rec_mem[b+10][23:0]);
		if (ram_mask_o !== rec_mem[b+11][23:0])
			report_mismatch("ram_mask_o", ram_mask_o, rec_mem[b+11][23:0]);
		if (pal_o !== rec_mem[b+12][0])
			report_mismatch("pal_o", pal_o, rec_mem[b+12][0]);
		for (int n = 0; n < WRAM_DEPTH; n++) begin
			@(posedge clk_sys);
			cpu_addr_i <= n[WRAM_ADDR_BITS-1:0];
			@(posedge clk_sys);
			@(negedge clk_sys);
			exp_byte = fill_value(pattern, n[WRAM_ADDR_BITS-1:0]);
			if (cpu_dout_o !== exp_byte)
				report_mismatch($sformatf("cpu_dout_o[%0h]", n), cpu_dout_o, exp_byte);
		end
	endtask

	task automatic run_cpu(input int b);
		@(posedge clk_sys);
		cpu_addr_i <= rec_mem[b+1][WRAM_ADDR_BITS-1:0];
		cpu_din_i  <= rec_mem[b+2][7:0];
		cpu_we_i   <= 1'b1;
		@(posedge clk_sys);
		cpu_we_i   <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		if (cpu_dout_o !== rec_mem[b+3][7:0])
			report_mismatch("cpu_dout_o", cpu_dout_o, rec_mem[b+3][7:0]);
	endtask

	task automatic run_cheat(input int b);
		cheat_code_t exp_code;
		exp_code = {rec_mem[b+9], rec_mem[b+10], rec_mem[b+11], rec_mem[b+12]};
		@(posedge clk_sys);
		valid_count      = 0;
		clear_count      = 0;
		ioctl_index_i    <= IDX_CODE;
		ioctl_download_i <= 1'b1;
		for (int w = 0; w < 8; w++)
			host_write(io_addr_t'(2 * w), rec_mem[b+1+w][15:0]);
		@(posedge clk_sys);
		ioctl_download_i <= 1'b0;
		repeat (2)
			@(posedge clk_sys);
		@(negedge clk_sys);
		if (valid_count != 1)
			report_mismatch("code_valid_o pulses", valid_count, 1);
		if (clear_count != 1)
			report_mismatch("code_clear_o pulses", clear_count, 1);
		if (code_o !== exp_code)
			report_mismatch("code_o", code_o, exp_code);
	endtask

	initial begin
		int kind;
		RESET            = 1'b1;
		ioctl_download_i = 1'b0;
		ioctl_index_i    = '0;
		ioctl_addr_i     = '0;
		ioctl_dout_i     = '0;
		ioctl_wr_i       = 1'b0;
		header_mode_i    = HDR_AUTO;
		region_sel_i     = REGION_AUTO;
		fill_pattern_i   = FILL_9966;
		cpu_addr_i       = '0;
		cpu_din_i        = '0;
		cpu_we_i         = 1'b0;
		errors           = 0;
		cycle_count      = 0;
		hold_count       = 0;
		valid_count      = 0;
		clear_count      = 0;
		for (int i = 0; i < MAX_RECS * REC_WORDS; i++)
			rec_mem[i] = '0;
		$readmemh("dv/cart_loader_input.txt", rec_mem);
		rec_count  = 0;
		cart_count = 0;
		while (rec_count < MAX_RECS && rec_mem[rec_count * REC_WORDS] != 0) begin
			if (rec_mem[rec_count * REC_WORDS] == 1)
				cart_count++;
			rec_count++;
		end
		// A load with its fill and readback fits in four fill lengths
		limit_cycles = 16 + rec_count * 64 + cart_count * 4 * FILL_CYCLES;
		if (rec_count == 0) begin
			errors++;
			$display("No stimulus records found in dv/cart_loader_input.txt");
		end
		repeat (10)
			@(posedge clk_sys);
		RESET <= 1'b0;
		@(negedge clk_sys);
		if (hold_o !== 1'b0)
			report_mismatch("hold_o", hold_o, 0);
		if (code_valid_o !== 1'b0 || code_clear_o !== 1'b0)
			report_mismatch("code_valid_o,code_clear_o", {code_valid_o, code_clear_o}, 0);
		if (rom_mask_o !== '0 || ram_mask_o !== '0)
			report_mismatch("rom_mask_o,ram_mask_o", {rom_mask_o, ram_mask_o}, 0);
		for (int r = 0; r < rec_count; r++) begin
			kind = rec_mem[r * REC_WORDS];
			case (kind)
				1: run_cart(r * REC_WORDS);
				2: run_cpu(r * REC_WORDS);
				3: run_cheat(r * REC_WORDS);
				default: begin
					errors++;
					$display("Record %0d has unknown kind %0d", r, kind);
				end
			endcase
		end
		$display("Records run %0d, errors %0d", rec_count, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/cart_loader_input.txt */
// kind 1 cart: mode region pattern word0 word2 info_addr info_word ram_word
//   type rom_mask ram_mask pal cpu_addr cpu_data; kind 2 cpu: addr data expect
// kind 3 cheat: words at offsets 0..14, then flags addr compare replace; 0 ends
1 0 0 0 2135 0100 0 0 0 21 7fff 1fff 1 12 ab 0
2 12 5a 5a 0 0 0 0 0 0 0 0 0 0 0 0
3 0001 0000 8000 007e 0000 0000 0042 0000 00000001 007e8000 00000000 00000042 0 0 0
1 0 0 1 3000 0000 0 0 0 30 3fffff 0 0 3ff c3 0
1 1 2 2 1234 0000 0 0 0 0 3fffff 0 1 0 77 0
1 2 1 3 5544 0100 81d6 0a00 0005 0 fffff 7fff 0 200 11 0
2 3fe c6 c6 0 0 0 0 0 0 0 0 0 0 0 0
1 3 3 0 0000 0000 101d6 0b00 0001 1 1fffff 7ff 1 104 ee 0
1 4 0 1 0000 0100 4101d6 0d00 0000 2 7fffff 0 1 3ff 00 0
3 1111 2222 3333 4444 5555 6666 7777 8888 22221111 44443333 66665555 88887777 0 0 0
0

/* files.f */
hdl/snes_load_pkg.sv
hdl/cart_header_decoder.sv
hdl/wram_fill_engine.sv
hdl/wram_store.sv
hdl/cheat_code_assembler.sv
hdl/cart_loader_top.sv
dv/cart_loader_assert.sv
dv/cart_loader_tb.sv

/* Bender.yml */
package:
  name: cart_loader

sources:
  - files:
      - hdl/snes_load_pkg.sv
      - hdl/cart_header_decoder.sv
      - hdl/wram_fill_engine.sv
      - hdl/wram_store.sv
      - hdl/cheat_code_assembler.sv
      - hdl/cart_loader_top.sv
  - target: simulation
    files:
      - dv/cart_loader_assert.sv
      - dv/cart_loader_tb.sv
